// ==== design/sd_clock_divider.sv ====
`include "sd_host_consts.svh"

module sd_clock_divider
    import sd_host_pkg::*;
(
    input  logic                  aclk_i,
    input  logic                  arst_n_i,
    input  logic [`DIVISOR_W-1:0] divisor_i,
    output logic                  sd_clk_o,
    output sd_tick_t              tick_o
);

    logic [`DIVISOR_W-1:0] count_q;

    // half period is divisor + 1 aclk cycles
    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q  <= `DIVISOR_W'(`DEFAULT_DIVISOR);
            sd_clk_o <= 1'b0;
            tick_o   <= '0;
        end else begin
            tick_o <= '0;
            if (count_q == '0) begin
                count_q     <= divisor_i;
                sd_clk_o    <= ~sd_clk_o;
                tick_o.rise <= ~sd_clk_o;
                tick_o.fall <= sd_clk_o;
            end else begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    a_single_edge: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
        !(tick_o.rise && tick_o.fall));

endmodule

// ==== design/sd_cmd_master.sv ====
`include "sd_host_consts.svh"

module sd_cmd_master
    import sd_host_pkg::*;
(
    input  logic               aclk_i,
    input  logic               arst_n_i,
    input  logic               start_i,
    input  cmd_frame_t         frame_i,
    input  cmd_result_t        result_i,
    output logic               serial_start_o,
    output cmd_frame_t         serial_frame_o,
    output logic               inhibit_o,
    output logic [`INT_W-1:0]  status_event_o,
    output logic [`RESP_W-1:0] response_o
);

    cmd_state_e        state_q;
    cmd_frame_t        frame_q;
    logic              checked;
    logic [`INT_W-1:0] events;

    // no checks on long, absent or missing responses
    assign checked = !result_i.timeout &&
                     (frame_q.resp_kind == RESP_48 || frame_q.resp_kind == RESP_48_BUSY);

    always_comb begin
        events                     = '0;
        events[`INT_CMD_COMPLETE]  = 1'b1;
        events[`INT_CMD_TIMEOUT]   = result_i.timeout;
        events[`INT_CMD_CRC_ERR]   = checked && frame_q.crc_check && !result_i.crc_ok;
        events[`INT_CMD_INDEX_ERR] = checked && frame_q.index_check && !result_i.index_ok;
    end

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q        <= CMD_IDLE;
            inhibit_o      <= 1'b0;
            status_event_o <= '0;
            response_o     <= '0;
        end else begin
            status_event_o <= '0;
            case (state_q)
                CMD_IDLE: begin
                    if (start_i) begin
                        inhibit_o <= 1'b1;
                        state_q   <= CMD_ISSUE;
                    end
                end
                CMD_ISSUE: state_q <= CMD_WAIT;
                CMD_WAIT: begin
                    if (result_i.done) begin
                        status_event_o <= events;
                        inhibit_o      <= 1'b0;
                        if (!result_i.timeout && frame_q.resp_kind != RESP_NONE) begin
                            response_o <= result_i.response;
                        end
                        state_q <= CMD_FINISH;
                    end
                end
                CMD_FINISH: state_q <= CMD_IDLE;
                default: state_q <= CMD_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk_i) begin
        if (state_q == CMD_IDLE && start_i) begin
            frame_q <= frame_i;
        end
    end

    assign serial_start_o = (state_q == CMD_ISSUE);
    assign serial_frame_o = frame_q;

endmodule

// ==== design/sd_cmd_serial.sv ====
`include "sd_host_consts.svh"

module sd_cmd_serial
    import sd_host_pkg::*;
(
    input  logic        aclk_i,
    input  logic        arst_n_i,
    input  sd_tick_t    tick_i,
    input  logic        start_i,
    input  cmd_frame_t  frame_i,
    input  logic        sd_cmd_i,
    output logic        sd_cmd_o,
    output logic        sd_cmd_oe_o,
    output cmd_result_t result_o
);

    localparam int SHORT_LEN = 48;
    localparam int LONG_LEN  = 136;
    localparam int WAIT_W    = $clog2(`CMD_TIMEOUT_TICKS);

    serial_state_e           state_q;
    resp_kind_e              kind_q;
    logic [SHORT_LEN-1:0]    tx_q;
    logic [LONG_LEN-1:0]     rx_q;
    logic [`CMD_INDEX_W-1:0] index_q;
    logic [7:0]              bit_cnt_q;
    logic [WAIT_W-1:0]       wait_cnt_q;
    logic                    timeout_q;
    logic [39:0]             tx_head;
    logic [7:0]              rx_len;
    logic [`RESP_W-1:0]      response;

    function automatic logic [6:0] crc7_of(input logic [39:0] bits);
        logic [6:0] crc;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            crc = crc7_next(crc, bits[i]);
        end
        return crc;
    endfunction

    // start bit, transmission bit, index, argument
    assign tx_head = {1'b0, 1'b1, frame_i.index, frame_i.argument};
    assign rx_len  = (kind_q == RESP_136) ? 8'(LONG_LEN) : 8'(SHORT_LEN);

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= SER_IDLE;
            kind_q      <= RESP_NONE;
            bit_cnt_q   <= '0;
            wait_cnt_q  <= '0;
            timeout_q   <= 1'b0;
            sd_cmd_o    <= 1'b1;
            sd_cmd_oe_o <= 1'b0;
        end else begin
            case (state_q)
                SER_IDLE: begin
                    if (start_i) begin
                        kind_q     <= frame_i.resp_kind;
                        bit_cnt_q  <= '0;
                        wait_cnt_q <= '0;
                        timeout_q  <= 1'b0;
                        state_q    <= SER_SEND;
                    end
                end
                SER_SEND: begin
                    if (tick_i.fall) begin
                        if (bit_cnt_q == 8'(SHORT_LEN)) begin
                            // end bit done, let go of the line
                            sd_cmd_o    <= 1'b1;
                            sd_cmd_oe_o <= 1'b0;
                            state_q     <= (kind_q == RESP_NONE) ? SER_DONE : SER_WAIT_RESP;
                        end else begin
                            sd_cmd_o    <= tx_q[SHORT_LEN-1];
                            sd_cmd_oe_o <= 1'b1;
                            bit_cnt_q   <= bit_cnt_q + 1'b1;
                        end
                    end
                end
                SER_WAIT_RESP: begin
                    if (tick_i.rise) begin
                        if (!sd_cmd_i) begin
                            bit_cnt_q <= 8'd1;
                            state_q   <= SER_RECV;
                        end else if (wait_cnt_q == WAIT_W'(`CMD_TIMEOUT_TICKS - 1)) begin
                            timeout_q <= 1'b1;
                            state_q   <= SER_DONE;
                        end else begin
                            wait_cnt_q <= wait_cnt_q + 1'b1;
                        end
                    end
                end
                SER_RECV: begin
                    if (tick_i.rise) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == rx_len - 8'd1) begin
                            state_q <= SER_DONE;
                        end
                    end
                end
                SER_DONE: state_q <= SER_IDLE;
                default: state_q <= SER_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk_i) begin
        if (state_q == SER_IDLE && start_i) begin
            tx_q    <= {tx_head, crc7_of(tx_head), 1'b1};
            index_q <= frame_i.index;
        end else if (state_q == SER_SEND && tick_i.fall) begin
            tx_q <= tx_q << 1;
        end
        // start bit is shifted in too
        if (tick_i.rise && (state_q == SER_RECV || (state_q == SER_WAIT_RESP && !sd_cmd_i))) begin
            rx_q <= {rx_q[LONG_LEN-2:0], sd_cmd_i};
        end
    end

    assign response = (kind_q == RESP_136) ? rx_q[127:8] : `RESP_W'(rx_q[39:8]);

    assign result_o = '{
        done:     state_q == SER_DONE,
        timeout:  timeout_q,
        crc_ok:   crc7_of(rx_q[47:8]) == rx_q[7:1],
        index_ok: rx_q[45:40] == index_q,
        rx_index: rx_q[45:40],
        response: response
    };

    a_oe_only_sending: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
        sd_cmd_oe_o |-> state_q == SER_SEND);

endmodule

// ==== design/sd_host_consts.svh ====
`ifndef SD_HOST_CONSTS_SVH
`define SD_HOST_CONSTS_SVH

`define REG_ADDR_W          4
`define REG_DATA_W          32
`define CMD_INDEX_W         6
`define DIVISOR_W           8
`define DEFAULT_DIVISOR     1
`define RESP_W              120
`define CMD_TIMEOUT_TICKS   64

// register word addresses
`define ADDR_ARGUMENT       4'd0
`define ADDR_COMMAND        4'd1
`define ADDR_RESP0          4'd2
`define ADDR_RESP1          4'd3
`define ADDR_RESP2          4'd4
`define ADDR_RESP3          4'd5
`define ADDR_DIVISOR        4'd6
`define ADDR_INT_STATUS     4'd7
`define ADDR_INT_STATUS_EN  4'd8
`define ADDR_INT_SIGNAL_EN  4'd9
`define ADDR_PRESENT        4'd10

// status bit positions
`define INT_CMD_COMPLETE    0
`define INT_CMD_TIMEOUT     1
`define INT_CMD_CRC_ERR     2
`define INT_CMD_INDEX_ERR   3
`define INT_W               4

`endif

// ==== design/sd_host_pkg.sv ====
`include "sd_host_consts.svh"

package sd_host_pkg;

    typedef enum logic [1:0] {
        RESP_NONE    = 2'd0,
        RESP_136     = 2'd1,
        RESP_48      = 2'd2,
        RESP_48_BUSY = 2'd3
    } resp_kind_e;

    // command register as software writes it
    typedef struct packed {
        logic [`CMD_INDEX_W-1:0] index;
        logic [1:0]              rsvd_hi;
        logic                    data_present;
        logic                    index_check;
        logic                    crc_check;
        logic                    rsvd_lo;
        resp_kind_e              resp_kind;
    } command_reg_t;

    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`REG_DATA_W-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic                   valid;
        logic [`REG_DATA_W-1:0] rdata;
    } reg_rsp_t;

    typedef struct packed {
        logic rise;
        logic fall;
    } sd_tick_t;

    typedef struct packed {
        logic [`CMD_INDEX_W-1:0] index;
        logic [31:0]             argument;
        logic                    index_check;
        logic                    crc_check;
        resp_kind_e              resp_kind;
    } cmd_frame_t;

    typedef struct packed {
        logic                    done;
        logic                    timeout;
        logic                    crc_ok;
        logic                    index_ok;
        logic [`CMD_INDEX_W-1:0] rx_index;
        logic [`RESP_W-1:0]      response;
    } cmd_result_t;

    typedef enum logic [1:0] {
        CMD_IDLE,
        CMD_ISSUE,
        CMD_WAIT,
        CMD_FINISH
    } cmd_state_e;

    typedef enum logic [2:0] {
        SER_IDLE,
        SER_SEND,
        SER_WAIT_RESP,
        SER_RECV,
        SER_DONE
    } serial_state_e;

    // one step of x^7 + x^3 + 1, msb first
    function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic bit_in);
        logic fb;
        fb = bit_in ^ crc[6];
        return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
    endfunction

endpackage

// ==== design/sd_host_regs.sv ====
`include "sd_host_consts.svh"

module sd_host_regs
    import sd_host_pkg::*;
(
    input  logic                   aclk_i,
    input  logic                   arst_n_i,
    input  reg_req_t               reg_req_i,
    output reg_rsp_t               reg_rsp_o,
    input  logic                   inhibit_i,
    input  logic [`INT_W-1:0]      status_event_i,
    input  logic [`RESP_W-1:0]     response_i,
    output logic [`DIVISOR_W-1:0]  divisor_o,
    output logic                   cmd_start_o,
    output cmd_frame_t             cmd_frame_o,
    output logic                   interrupt_o
);

    logic [`REG_DATA_W-1:0] argument_q;
    command_reg_t           command_q;
    logic [`INT_W-1:0]      int_status_q;
    logic [`INT_W-1:0]      int_status_en_q;
    logic [`INT_W-1:0]      int_signal_en_q;
    logic [`INT_W-1:0]      w1c_mask;
    logic                   wr_en;
    logic                   rd_en;
    logic                   rsp_valid_q;
    logic [`REG_DATA_W-1:0] rsp_data_q;
    logic [`REG_DATA_W-1:0] rdata;

    assign wr_en = reg_req_i.valid && reg_req_i.write;
    assign rd_en = reg_req_i.valid && !reg_req_i.write;
    assign w1c_mask = (wr_en && reg_req_i.addr == `ADDR_INT_STATUS) ?
                      reg_req_i.wdata[`INT_W-1:0] : '0;

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            argument_q      <= '0;
            command_q       <= '0;
            divisor_o       <= `DIVISOR_W'(`DEFAULT_DIVISOR);
            int_status_en_q <= '0;
            int_signal_en_q <= '0;
            cmd_start_o     <= 1'b0;
        end else begin
            cmd_start_o <= 1'b0;
            if (wr_en) begin
                case (reg_req_i.addr)
                    `ADDR_ARGUMENT: argument_q <= reg_req_i.wdata;
                    `ADDR_COMMAND: begin
                        // dropped while a command is in flight
                        if (!inhibit_i && !cmd_start_o) begin
                            command_q   <= command_reg_t'(reg_req_i.wdata[$bits(command_reg_t)-1:0]);
                            cmd_start_o <= 1'b1;
                        end
                    end
                    `ADDR_DIVISOR: divisor_o <= reg_req_i.wdata[`DIVISOR_W-1:0];
                    `ADDR_INT_STATUS_EN: int_status_en_q <= reg_req_i.wdata[`INT_W-1:0];
                    `ADDR_INT_SIGNAL_EN: int_signal_en_q <= reg_req_i.wdata[`INT_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // a new event wins over a clear in the same cycle
    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            int_status_q <= '0;
            interrupt_o  <= 1'b0;
        end else begin
            int_status_q <= (int_status_q & ~w1c_mask) | (status_event_i & int_status_en_q);
            interrupt_o  <= |(int_status_q & int_signal_en_q);
        end
    end

    always_comb begin
        case (reg_req_i.addr)
            `ADDR_ARGUMENT:      rdata = argument_q;
            `ADDR_COMMAND:       rdata = `REG_DATA_W'(command_q);
            `ADDR_RESP0:         rdata = response_i[31:0];
            `ADDR_RESP1:         rdata = response_i[63:32];
            `ADDR_RESP2:         rdata = response_i[95:64];
            `ADDR_RESP3:         rdata = `REG_DATA_W'(response_i[`RESP_W-1:96]);
            `ADDR_DIVISOR:       rdata = `REG_DATA_W'(divisor_o);
            `ADDR_INT_STATUS:    rdata = `REG_DATA_W'(int_status_q);
            `ADDR_INT_STATUS_EN: rdata = `REG_DATA_W'(int_status_en_q);
            `ADDR_INT_SIGNAL_EN: rdata = `REG_DATA_W'(int_signal_en_q);
            `ADDR_PRESENT:       rdata = `REG_DATA_W'(inhibit_i);
            default:             rdata = '0;
        endcase
    end

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= rd_en;
        end
    end

    always_ff @(posedge aclk_i) begin
        if (rd_en) begin
            rsp_data_q <= rdata;
        end
    end

    assign reg_rsp_o = '{valid: rsp_valid_q, rdata: rsp_data_q};

    assign cmd_frame_o = '{
        index:       command_q.index,
        argument:    argument_q,
        index_check: command_q.index_check,
        crc_check:   command_q.crc_check,
        resp_kind:   command_q.resp_kind
    };

    a_no_start_inhibited: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
        cmd_start_o |-> !inhibit_i);

endmodule

// ==== design/sd_host_top.sv ====
`include "sd_host_consts.svh"

module sd_host_top
    import sd_host_pkg::*;
(
    input  logic     aclk_i,
    input  logic     arst_n_i,
    input  reg_req_t reg_req_i,
    output reg_rsp_t reg_rsp_o,
    output logic     sd_clk_o,
    output logic     sd_cmd_o,
    output logic     sd_cmd_oe_o,
    output logic     interrupt_o,
    input  logic     sd_cmd_i
);

    logic [`DIVISOR_W-1:0] divisor;
    sd_tick_t              tick;
    logic                  cmd_start;
    cmd_frame_t            cmd_frame;
    logic                  serial_start;
    cmd_frame_t            serial_frame;
    cmd_result_t           result;
    logic                  inhibit;
    logic [`INT_W-1:0]     status_event;
    logic [`RESP_W-1:0]    response;

    sd_clock_divider u_clock_divider (
        .aclk_i    (aclk_i),
        .arst_n_i  (arst_n_i),
        .divisor_i (divisor),
        .sd_clk_o  (sd_clk_o),
        .tick_o    (tick)
    );

    sd_host_regs u_regs (
        .aclk_i         (aclk_i),
        .arst_n_i       (arst_n_i),
        .reg_req_i      (reg_req_i),
        .reg_rsp_o      (reg_rsp_o),
        .inhibit_i      (inhibit),
        .status_event_i (status_event),
        .response_i     (response),
        .divisor_o      (divisor),
        .cmd_start_o    (cmd_start),
        .cmd_frame_o    (cmd_frame),
        .interrupt_o    (interrupt_o)
    );

    sd_cmd_master u_cmd_master (
        .aclk_i         (aclk_i),
        .arst_n_i       (arst_n_i),
        .start_i        (cmd_start),
        .frame_i        (cmd_frame),
        .result_i       (result),
        .serial_start_o (serial_start),
        .serial_frame_o (serial_frame),
        .inhibit_o      (inhibit),
        .status_event_o (status_event),
        .response_o     (response)
    );

    sd_cmd_serial u_cmd_serial (
        .aclk_i      (aclk_i),
        .arst_n_i    (arst_n_i),
        .tick_i      (tick),
        .start_i     (serial_start),
        .frame_i     (serial_frame),
        .sd_cmd_i    (sd_cmd_i),
        .sd_cmd_o    (sd_cmd_o),
        .sd_cmd_oe_o (sd_cmd_oe_o),
        .result_o    (result)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal --top-module sd_host_tb -f verilog.f \
        -o sd_host_sim \
    && ./obj_dir/sd_host_sim | tee sim.log \
    && grep -q "All tests passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tests/sd_card_model.sv ====
module sd_card_model (
    input  logic         sd_clk_i,
    input  logic         cmd_i,
    input  logic         cmd_oe_i,
    input  logic [135:0] reply_i,
    input  int           reply_len_i,
    input  int           reply_gap_i,
    input  logic         silent_i,
    output logic         cmd_o,
    output logic [47:0]  frame_o,
    output int           frame_count_o
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [47:0] shift;

    initial begin
        cmd_o = 1'b1;
        frame_o = '0;
        frame_count_o = 0;
        shift = '0;
        forever begin
            @(posedge sd_clk_i);
            if (cmd_oe_i && !cmd_i) begin
                // start bit seen, collect the other 47
                shift = '0;
                repeat (47) begin
                    @(posedge sd_clk_i);
                    shift = {shift[46:0], cmd_i};
                end
                frame_o = shift;
                frame_count_o++;
                if (!silent_i) begin
                    repeat (reply_gap_i) @(negedge sd_clk_i);
                    // msb of the reply goes out first
                    for (int i = reply_len_i - 1; i >= 0; i--) begin
                        @(negedge sd_clk_i);
                        cmd_o = reply_i[i];
                    end
                    @(negedge sd_clk_i);
                    cmd_o = 1'b1;
                end
            end
        end
    end

endmodule

// ==== tests/sd_host_tb.sv ====
`include "sd_host_consts.svh"

module sd_host_tb
    import sd_host_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // 6 tests x 3 commands x 200 sd ticks x 4 aclk cycles, plus margin
    localparam int MAX_CYCLES = 20000;

    localparam logic [31:0] ST_COMPLETE  = 32'd1 << `INT_CMD_COMPLETE;
    localparam logic [31:0] ST_TIMEOUT   = 32'd1 << `INT_CMD_TIMEOUT;
    localparam logic [31:0] ST_CRC_ERR   = 32'd1 << `INT_CMD_CRC_ERR;
    localparam logic [31:0] ST_INDEX_ERR = 32'd1 << `INT_CMD_INDEX_ERR;

    logic         aclk = 1'b0;
    logic         arst_n;
    reg_req_t     req;
    reg_rsp_t     rsp;
    logic         sd_clk;
    logic         sd_cmd_host;
    logic         sd_cmd_oe;
    logic         sd_cmd_card;
    logic         irq;
    logic [135:0] reply_bits;
    int           reply_len;
    int           reply_gap;
    logic         card_silent;
    logic [47:0]  card_frame;
    int           frame_count;
    logic [119:0] expect_resp;
    int           errors = 0;
    int           checks = 0;
    int           cycles = 0;
    int           seed;

    sd_host_top uut (
        .aclk_i      (aclk),
        .arst_n_i    (arst_n),
        .reg_req_i   (req),
        .reg_rsp_o   (rsp),
        .sd_clk_o    (sd_clk),
        .sd_cmd_o    (sd_cmd_host),
        .sd_cmd_oe_o (sd_cmd_oe),
        .interrupt_o (irq),
        .sd_cmd_i    (sd_cmd_card)
    );

    sd_card_model card (
        .sd_clk_i      (sd_clk),
        .cmd_i         (sd_cmd_host),
        .cmd_oe_i      (sd_cmd_oe),
        .reply_i       (reply_bits),
        .reply_len_i   (reply_len),
        .reply_gap_i   (reply_gap),
        .silent_i      (card_silent),
        .cmd_o         (sd_cmd_card),
        .frame_o       (card_frame),
        .frame_count_o (frame_count)
    );

    initial begin
        forever #10 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    // x^7 + x^3 + 1, msb first
    function automatic logic [6:0] crc7(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    function automatic logic [47:0] short_reply(input logic [5:0] idx,
                                                input logic [31:0] payload,
                                                input logic bad_crc);
        logic [39:0] head;
        head = {2'b00, idx, payload};
        return {head, crc7(head) ^ {6'd0, bad_crc}, 1'b1};
    endfunction

    function automatic logic [31:0] command_word(input logic [5:0] idx, input logic idx_chk,
                                                 input logic crc_chk, input logic [1:0] kind);
        return {18'd0, idx, 3'b000, idx_chk, crc_chk, 1'b0, kind};
    endfunction

    task automatic check_equal(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error: %s is %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
        @(negedge aclk);
        req = '{valid: 1'b1, write: 1'b1, addr: addr, wdata: data};
        @(negedge aclk);
        req = '0;
    endtask

    task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
        @(negedge aclk);
        req = '{valid: 1'b1, write: 1'b0, addr: addr, wdata: 32'd0};
        @(negedge aclk);
        req = '0;
        check_equal("reg_rsp_o.valid", rsp.valid, 1'b1);
        data = rsp.rdata;
    endtask

    task automatic read_expect(input string name, input logic [3:0] addr,
                               input logic [31:0] expected);
        logic [31:0] data;
        reg_read(addr, data);
        check_equal(name, data, expected);
    endtask

    task automatic wait_command_done();
        logic [31:0] present;
        present = 32'd1;
        while (present[0]) begin
            reg_read(`ADDR_PRESENT, present);
        end
    endtask

    task automatic send_command(input logic [5:0] idx, input logic [31:0] arg,
                                input logic idx_chk, input logic crc_chk,
                                input logic [1:0] kind);
        reg_write(`ADDR_ARGUMENT, arg);
        reg_write(`ADDR_COMMAND, command_word(idx, idx_chk, crc_chk, kind));
        wait_command_done();
    endtask

    task automatic load_reply(input logic [135:0] bits, input int len, input int gap,
                              input logic silent);
        reply_bits = bits;
        reply_len = len;
        reply_gap = gap;
        card_silent = silent;
    endtask

    task automatic check_response(input logic [119:0] expected);
        read_expect("resp0 register", `ADDR_RESP0, expected[31:0]);
        read_expect("resp1 register", `ADDR_RESP1, expected[63:32]);
        read_expect("resp2 register", `ADDR_RESP2, expected[95:64]);
        read_expect("resp3 register", `ADDR_RESP3, {8'd0, expected[119:96]});
    endtask

    task automatic clear_status();
        reg_write(`ADDR_INT_STATUS, 32'hf);
    endtask

    task automatic test_reset_and_registers();
        logic [31:0] arg;
        int          high_cycles;
        check_equal("sd_cmd_oe_o", sd_cmd_oe, 1'b0);
        check_equal("sd_cmd_o", sd_cmd_host, 1'b1);
        check_equal("interrupt_o", irq, 1'b0);
        check_equal("reg_rsp_o.valid", rsp.valid, 1'b0);
        for (int a = 0; a < 16; a++) begin
            read_expect($sformatf("register %0d", a), 4'(a),
                        (a == `ADDR_DIVISOR) ? 32'(`DEFAULT_DIVISOR) : 32'd0);
        end
        arg = $random(seed);
        reg_write(`ADDR_ARGUMENT, arg);
        read_expect("argument register", `ADDR_ARGUMENT, arg);
        reg_write(`ADDR_INT_STATUS_EN, 32'hf);
        reg_write(`ADDR_INT_SIGNAL_EN, 32'h5);
        read_expect("status enable register", `ADDR_INT_STATUS_EN, 32'hf);
        read_expect("signal enable register", `ADDR_INT_SIGNAL_EN, 32'h5);
        reg_write(`ADDR_INT_SIGNAL_EN, ST_COMPLETE);
        // high phase is divisor + 1 aclk cycles
        reg_write(`ADDR_DIVISOR, 32'd3);
        @(posedge sd_clk);
        @(posedge sd_clk);
        @(negedge aclk);
        high_cycles = 0;
        while (sd_clk) begin
            high_cycles++;
            @(negedge aclk);
        end
        check_equal("sd_clk_o high cycles", high_cycles, 3 + 1);
        reg_write(`ADDR_DIVISOR, 32'd1);
    endtask

    task automatic test_short_response();
        logic [5:0]  idx;
        logic [31:0] arg;
        logic [31:0] payload;
        idx = 6'd17;
        arg = $random(seed);
        payload = $random(seed);
        clear_status();
        load_reply(136'(short_reply(idx, payload, 1'b0)), 48, 3, 1'b0);
        send_command(idx, arg, 1'b1, 1'b1, RESP_48);
        check_equal("card frame index", card_frame[45:40], idx);
        check_equal("card frame argument", card_frame[39:8], arg);
        check_equal("card frame crc7", card_frame[7:1], crc7({2'b01, idx, arg}));
        expect_resp = {88'd0, payload};
        check_response(expect_resp);
        read_expect("status register", `ADDR_INT_STATUS, ST_COMPLETE);
        check_equal("interrupt_o", irq, 1'b1);
        clear_status();
        repeat (2) @(negedge aclk);
        check_equal("interrupt_o", irq, 1'b0);
    endtask

    task automatic test_error_checks();
        logic [5:0]  idx;
        logic [31:0] payload;
        idx = 6'd8;
        payload = $random(seed);
        load_reply(136'(short_reply(idx, payload, 1'b1)), 48, 2, 1'b0);
        send_command(idx, $random(seed), 1'b1, 1'b1, RESP_48);
        read_expect("status register", `ADDR_INT_STATUS, ST_COMPLETE | ST_CRC_ERR);
        clear_status();
        load_reply(136'(short_reply(idx ^ 6'd1, payload, 1'b0)), 48, 2, 1'b0);
        send_command(idx, $random(seed), 1'b1, 1'b1, RESP_48);
        read_expect("status register", `ADDR_INT_STATUS, ST_COMPLETE | ST_INDEX_ERR);
        clear_status();
        // both faults at once, nothing checked
        load_reply(136'(short_reply(idx ^ 6'd1, payload, 1'b1)), 48, 2, 1'b0);
        send_command(idx, $random(seed), 1'b0, 1'b0, RESP_48);
        read_expect("status register", `ADDR_INT_STATUS, ST_COMPLETE);
        clear_status();
        expect_resp = {88'd0, payload};
    endtask

    task automatic test_timeout();
        load_reply('0, 0, 0, 1'b1);
        send_command(6'd13, $random(seed), 1'b1, 1'b1, RESP_48);
        read_expect("status register", `ADDR_INT_STATUS, ST_COMPLETE | ST_TIMEOUT);
        check_response(expect_resp);
        clear_status();
    endtask

    task automatic test_long_response();
        logic [127:0] bits;
        bits = {$random(seed), $random(seed), $random(seed), $random(seed)};
        load_reply({2'b00, 6'h3f, bits[119:0], 8'hff}, 136, 4, 1'b0);
        send_command(6'd2, 32'd0, 1'b1, 1'b1, RESP_136);
        expect_resp = bits[119:0];
        check_response(expect_resp);
        read_expect("status register", `ADDR_INT_STATUS, ST_COMPLETE);
        clear_status();
    endtask

    task automatic test_inhibit_and_no_response();
        logic [31:0] payload;
        int          count_before;
        load_reply('0, 0, 0, 1'b1);
        send_command(6'd0, 32'd0, 1'b0, 1'b0, RESP_NONE);
        read_expect("status register", `ADDR_INT_STATUS, ST_COMPLETE);
        check_equal("card frame index", card_frame[45:40], 6'd0);
        clear_status();
        // complete is not enabled, so nothing is stored
        reg_write(`ADDR_INT_STATUS_EN, ST_TIMEOUT);
        send_command(6'd0, 32'd0, 1'b0, 1'b0, RESP_NONE);
        read_expect("status register", `ADDR_INT_STATUS, 32'd0);
        reg_write(`ADDR_INT_STATUS_EN, 32'hf);
        payload = $random(seed);
        count_before = frame_count;
        load_reply(136'(short_reply(6'd5, payload, 1'b0)), 48, 3, 1'b0);
        reg_write(`ADDR_ARGUMENT, $random(seed));
        reg_write(`ADDR_COMMAND, command_word(6'd5, 1'b1, 1'b1, RESP_48));
        read_expect("present register", `ADDR_PRESENT, 32'd1);
        reg_write(`ADDR_COMMAND, command_word(6'd9, 1'b1, 1'b1, RESP_48));
        read_expect("command register", `ADDR_COMMAND,
                    command_word(6'd5, 1'b1, 1'b1, RESP_48));
        wait_command_done();
        // long enough for a second frame to reach the card
        repeat (300) @(negedge aclk);
        read_expect("present register", `ADDR_PRESENT, 32'd0);
        check_equal("card frame count", frame_count, count_before + 1);
        check_equal("card frame index", card_frame[45:40], 6'd5);
        read_expect("status register", `ADDR_INT_STATUS, ST_COMPLETE);
        expect_resp = {88'd0, payload};
        check_response(expect_resp);
        clear_status();
    endtask

    initial begin
        seed = 27655;
        req = '0;
        arst_n = 1'b0;
        reply_bits = '0;
        reply_len = 0;
        reply_gap = 0;
        card_silent = 1'b1;
        expect_resp = '0;
        repeat (2) @(negedge aclk);
        arst_n = 1'b1;
        test_reset_and_registers();
        test_short_response();
        test_error_checks();
        // stored long response differs from what a short timeout would copy
        test_long_response();
        test_timeout();
        test_inhibit_and_no_response();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+design
design/sd_host_pkg.sv
design/sd_clock_divider.sv
design/sd_host_regs.sv
design/sd_cmd_master.sv
design/sd_cmd_serial.sv
design/sd_host_top.sv
tests/sd_card_model.sv
tests/sd_host_tb.sv
